// ==== hw/imu_link_pkg.sv ====
`default_nettype none

package imu_link_pkg;

    // Packet geometry
    localparam int PACKET_BYTES = 16;
    localparam int PACKET_BITS  = PACKET_BYTES * 8;      // 128 bits on the wire
    localparam int SAMPLE_W     = 16;                    // Sensor word width
    localparam int BIT_CNT_W    = $clog2(PACKET_BITS + 1); // Counts 0..128

    localparam logic [7:0] HEADER_BYTE = 8'hAA;          // Sync byte, always first

    // Bit positions inside the flags byte
    localparam int FLAG_QUAT_BIT = 0;
    localparam int FLAG_GYRO_BIT = 1;

    // Serializer FSM encodings
    localparam logic [1:0] ST_IDLE         = 2'd0;
    localparam logic [1:0] ST_SENDING      = 2'd1;
    localparam logic [1:0] ST_WAIT_RELEASE = 2'd2;

    // Field order is wire order, header lands in the top byte
    typedef struct packed {
        logic [7:0]                 header;
        logic signed [SAMPLE_W-1:0] quat_w;
        logic signed [SAMPLE_W-1:0] quat_x;
        logic signed [SAMPLE_W-1:0] quat_y;
        logic signed [SAMPLE_W-1:0] quat_z;
        logic signed [SAMPLE_W-1:0] gyro_x;
        logic signed [SAMPLE_W-1:0] gyro_y;
        logic signed [SAMPLE_W-1:0] gyro_z;
        logic [7:0]                 flags;  // Bit 0 quat updated, bit 1 gyro updated
    } imu_packet_t;

    // Framer fills fields, serializer shifts the flat word out MSB first
    typedef union packed {
        imu_packet_t            fields;
        logic [PACKET_BITS-1:0] bits;
    } imu_packet_u;

endpackage

`default_nettype wire

// ==== hw/imu_packet_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One packet snapshot plus its four-phase req/ack pair
interface imu_packet_if;

    import imu_link_pkg::*;

    imu_packet_u packet;  // Held stable by the framer while req is high
    logic        req;     // Framer: snapshot valid
    logic        ack;     // Serializer: snapshot copied

    // Sequence is req up, ack up, req down, ack down
    // New req only once ack is back low

    modport framer (
        output packet,
        output req,
        input  ack
    );

    modport serializer (
        input  packet,
        input  req,
        output ack
    );

endinterface

`default_nettype wire

// ==== hw/imu_packet_framer.sv ====
`timescale 1ns/10ps
`default_nettype none

module imu_packet_framer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   quat_valid,  // One-cycle sample strobe
    input  logic                                   gyro_valid,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] quat_w,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] quat_x,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] quat_y,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] quat_z,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] gyro_x,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] gyro_y,
    input  logic signed [imu_link_pkg::SAMPLE_W-1:0] gyro_z,
    imu_packet_if.framer                           pkt
);

    import imu_link_pkg::*;

    // Latest samples, always overwritten by the newest strobe
    logic signed [SAMPLE_W-1:0] quat_w_q;
    logic signed [SAMPLE_W-1:0] quat_x_q;
    logic signed [SAMPLE_W-1:0] quat_y_q;
    logic signed [SAMPLE_W-1:0] quat_z_q;
    logic signed [SAMPLE_W-1:0] gyro_x_q;
    logic signed [SAMPLE_W-1:0] gyro_y_q;
    logic signed [SAMPLE_W-1:0] gyro_z_q;

    logic       quat_upd;   // Sticky, new quaternion since last launch
    logic       gyro_upd;   // Sticky, new gyro since last launch
    logic       launch;     // Take a snapshot this cycle
    logic [7:0] flags_now;  // Flags byte for the snapshot

    // Something new to send and handshake fully back to rest
    assign launch = (quat_upd || gyro_upd) && !pkt.req && !pkt.ack;

    always_comb begin
        flags_now = '0;
        flags_now[FLAG_QUAT_BIT] = quat_upd;
        flags_now[FLAG_GYRO_BIT] = gyro_upd;
    end

    // Staging registers
    always_ff @(posedge clk) begin
        if (reset) begin
            quat_w_q <= '0;
            quat_x_q <= '0;
            quat_y_q <= '0;
            quat_z_q <= '0;
            gyro_x_q <= '0;
            gyro_y_q <= '0;
            gyro_z_q <= '0;
        end else begin
            if (quat_valid) begin
                quat_w_q <= quat_w;
                quat_x_q <= quat_x;
                quat_y_q <= quat_y;
                quat_z_q <= quat_z;
            end
            if (gyro_valid) begin
                gyro_x_q <= gyro_x;
                gyro_y_q <= gyro_y;
                gyro_z_q <= gyro_z;
            end
        end
    end

    // Update flags
    // A strobe on the launch cycle wins, it belongs to the next packet
    always_ff @(posedge clk) begin
        if (reset) begin
            quat_upd <= 1'b0;
            gyro_upd <= 1'b0;
        end else begin
            quat_upd <= quat_valid || (quat_upd && !launch);
            gyro_upd <= gyro_valid || (gyro_upd && !launch);
        end
    end

    // Snapshot, written through the field view
    always_ff @(posedge clk) begin
        if (launch) begin
            pkt.packet.fields.header <= HEADER_BYTE;
            pkt.packet.fields.quat_w <= quat_w_q;
            pkt.packet.fields.quat_x <= quat_x_q;
            pkt.packet.fields.quat_y <= quat_y_q;
            pkt.packet.fields.quat_z <= quat_z_q;
            pkt.packet.fields.gyro_x <= gyro_x_q;
            pkt.packet.fields.gyro_y <= gyro_y_q;
            pkt.packet.fields.gyro_z <= gyro_z_q;
            pkt.packet.fields.flags  <= flags_now;  // Flags travel with the words
        end
    end

    // Req side of the four-phase exchange
    always_ff @(posedge clk) begin
        if (reset) begin
            pkt.req <= 1'b0;
        end else if (launch) begin
            pkt.req <= 1'b1;            // Snapshot is registered in the same edge
        end else if (pkt.req && pkt.ack) begin
            pkt.req <= 1'b0;            // Serializer has its copy
        end
    end

    // Under back-pressure the flags accumulate and staging keeps the
    // newest words, so only one packet is ever pending behind done

endmodule

`default_nettype wire

// ==== hw/spi_packet_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

// SPI slave transmitter, mode 0
// MCU samples on rising sck, we move sdo after falling sck
// sck must be at most clk/8 for the two-flop sampling to keep up
module spi_packet_tx (
    input  logic               clk,
    input  logic               reset,
    input  logic               sck,   // From MCU, async to clk
    input  logic               sdi,   // MOSI, no commands decoded yet
    input  logic               load,  // MCU read confirm
    output logic               sdo,   // MISO
    output logic               done,  // Packet ready for the MCU
    imu_packet_if.serializer   pkt
);

    import imu_link_pkg::*;

    logic sck_meta;   // First sync stage
    logic sck_sync;
    logic sck_prev;   // For edge detect
    logic load_meta;
    logic load_sync;
    logic sdi_meta;
    logic sdi_sync;

    logic                   sck_fall;
    logic                   accept;
    logic                   shift_en;
    logic                   bits_left;  // Still inside the 128-bit frame
    logic [1:0]             state;
    logic [PACKET_BITS-1:0] shift_q;    // Current packet, MSB on the pin
    logic [BIT_CNT_W-1:0]   bit_cnt;    // Falling edges seen this packet

    // Input synchronisers
    always_ff @(posedge clk) begin
        if (reset) begin
            sck_meta  <= 1'b0;
            sck_sync  <= 1'b0;
            sck_prev  <= 1'b0;
            load_meta <= 1'b0;
            load_sync <= 1'b0;
            sdi_meta  <= 1'b0;
            sdi_sync  <= 1'b0;
        end else begin
            sck_meta  <= sck;
            sck_sync  <= sck_meta;
            sck_prev  <= sck_sync;
            load_meta <= load;
            load_sync <= load_meta;
            sdi_meta  <= sdi;
            sdi_sync  <= sdi_meta;
        end
    end

    assign sck_fall  = sck_prev && !sck_sync;  // Shift lands 2-3 clk after the pin edge
    assign bits_left = (bit_cnt != BIT_CNT_W'(PACKET_BITS));

    // New packet only with the MCU side fully at rest
    assign accept   = (state == ST_IDLE) && pkt.req && !done && !load_sync;
    assign shift_en = (state == ST_SENDING) && sck_fall && bits_left;

    // Shift register
    // MOSI bits fill in from the bottom, unused for now
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= pkt.packet.bits;
        end else if (shift_en) begin
            shift_q <= {shift_q[PACKET_BITS-2:0], sdi_sync};
        end
    end

    // Bit counter, stops shifting after the last bit
    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (accept) begin
            bit_cnt <= '0;
        end else if (shift_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Control FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            pkt.ack <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        pkt.ack <= 1'b1;      // Copy taken
                        done    <= 1'b1;      // Tell the MCU
                        state   <= ST_SENDING;
                    end
                end
                ST_SENDING: begin
                    // MCU says it has read, may come early too
                    if (load_sync) begin
                        pkt.ack <= 1'b0;
                        done    <= 1'b0;
                        state   <= ST_WAIT_RELEASE;
                    end
                end
                ST_WAIT_RELEASE: begin
                    if (!load_sync) begin
                        state <= ST_IDLE;     // Four-phase closed on both sides
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    pkt.ack <= 1'b0;
                    done    <= 1'b0;
                end
            endcase
        end
    end

    // Low outside a frame so the line is quiet between packets
    assign sdo = (state == ST_SENDING) && bits_left && shift_q[PACKET_BITS-1];

endmodule

`default_nettype wire

// ==== hw/imu_spi_link.sv ====
`timescale 1ns/10ps
`default_nettype none

// IMU packet link top
// Sensor controller samples in, 16-byte packets out to the MCU over SPI
module imu_spi_link (
    input  logic               clk,
    input  logic               reset,
    // MCU side, MCU is SPI master
    input  logic               sck,
    input  logic               sdi,
    input  logic               load,
    output logic               sdo,
    output logic               done,
    // Sensor controller side
    input  logic               quat_valid,
    input  logic               gyro_valid,
    input  logic signed [15:0] quat_w,
    input  logic signed [15:0] quat_x,
    input  logic signed [15:0] quat_y,
    input  logic signed [15:0] quat_z,
    input  logic signed [15:0] gyro_x,
    input  logic signed [15:0] gyro_y,
    input  logic signed [15:0] gyro_z
);

    // Snapshot and req/ack between framer and serializer
    imu_packet_if pkt_if ();

    // Latches samples and launches snapshots
    imu_packet_framer imu_packet_framer_inst (
        .clk        (clk),
        .reset      (reset),
        .quat_valid (quat_valid),
        .gyro_valid (gyro_valid),
        .quat_w     (quat_w),
        .quat_x     (quat_x),
        .quat_y     (quat_y),
        .quat_z     (quat_z),
        .gyro_x     (gyro_x),
        .gyro_y     (gyro_y),
        .gyro_z     (gyro_z),
        .pkt        (pkt_if.framer)
    );

    // Shifts the packet out and runs done/load with the MCU
    spi_packet_tx spi_packet_tx_inst (
        .clk   (clk),
        .reset (reset),
        .sck   (sck),
        .sdi   (sdi),
        .load  (load),
        .sdo   (sdo),
        .done  (done),
        .pkt   (pkt_if.serializer)
    );

endmodule

`default_nettype wire

// ==== bench/imu_spi_link_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module imu_spi_link_tb;

    import imu_link_pkg::*;

    localparam int CLK_HALF        = 5;     // 10 ns period
    localparam int DRIVE_DELAY     = 1;     // Inputs move 1 ns after the rising edge
    localparam int RESET_CYCLES    = 3;
    localparam int SCK_PHASE       = 5;     // Half sck period in clk cycles so sck runs at clk/10
    localparam int PAUSE_CYCLES    = 20;    // W command
    localparam int DONE_WAIT_MAX   = 2000;  // Per done edge
    localparam int CYCLES_PER_LINE = 3000;  // Watchdog budget per stim line

    logic               clk;
    logic               reset;
    logic               sck;
    logic               sdi;
    logic               load;
    logic               quat_valid;
    logic               gyro_valid;
    logic signed [15:0] quat_w;
    logic signed [15:0] quat_x;
    logic signed [15:0] quat_y;
    logic signed [15:0] quat_z;
    logic signed [15:0] gyro_x;
    logic signed [15:0] gyro_y;
    logic signed [15:0] gyro_z;
    logic               sdo;
    logic               done;

    logic [7:0] exp_bytes [PACKET_BYTES];  // Expected packet of the current R line
    int         watchdog_cycles;           // Zero until the stim file is counted

    imu_spi_link imu_spi_link_inst (
        .clk        (clk),
        .reset      (reset),
        .sck        (sck),
        .sdi        (sdi),
        .load       (load),
        .sdo        (sdo),
        .done       (done),
        .quat_valid (quat_valid),
        .gyro_valid (gyro_valid),
        .quat_w     (quat_w),
        .quat_x     (quat_x),
        .quat_y     (quat_y),
        .quat_z     (quat_z),
        .gyro_x     (gyro_x),
        .gyro_y     (gyro_y),
        .gyro_z     (gyro_z)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // Land just after the next rising edge where outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_quat(input logic [15:0] w, input logic [15:0] x,
                             input logic [15:0] y, input logic [15:0] z);
        quat_w     = w;
        quat_x     = x;
        quat_y     = y;
        quat_z     = z;
        quat_valid = 1'b1;   // One-cycle strobe
        next_cycle();
        quat_valid = 1'b0;
    endtask

    task automatic send_gyro(input logic [15:0] x, input logic [15:0] y,
                             input logic [15:0] z);
        gyro_x     = x;
        gyro_y     = y;
        gyro_z     = z;
        gyro_valid = 1'b1;
        next_cycle();
        gyro_valid = 1'b0;
    endtask

    // No packet may show up during this window
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            next_cycle();
            assert (!done) else
                stop_on_error($sformatf("Mismatch at %0d ns: done high during idle wait",
                                        $time));
        end
    endtask

    // SPI master in mode 0 followed by the load handshake
    task automatic read_packet(input int pkt_idx);
        logic [7:0] got_byte;
        logic [3:0] byte_sel;
        int         bit_idx;
        int         wait_cnt;
        wait_cnt = 0;
        while (!done && wait_cnt < DONE_WAIT_MAX) begin
            next_cycle();
            wait_cnt++;
        end
        assert (done) else
            stop_on_error($sformatf("done never rose for packet %0d", pkt_idx));
        got_byte = '0;
        byte_sel = '0;
        for (bit_idx = 0; bit_idx < PACKET_BITS; bit_idx++) begin
            sck = 1'b1;                           // MCU samples on this edge
            repeat (SCK_PHASE) next_cycle();
            got_byte = {got_byte[6:0], sdo};      // MSB first
            sck = 1'b0;                           // DUT moves sdo after this edge
            repeat (SCK_PHASE) next_cycle();
            if (bit_idx % 8 == 7) begin
                assert (got_byte == exp_bytes[byte_sel]) else
                    stop_on_error($sformatf(
                        "Mismatch at %0d ns: packet %0d byte %0d read %02h expected %02h",
                        $time, pkt_idx, byte_sel, got_byte, exp_bytes[byte_sel]));
                byte_sel = byte_sel + 4'd1;
            end
        end
        load = 1'b1;                              // Confirm the read
        wait_cnt = 0;
        while (done && wait_cnt < DONE_WAIT_MAX) begin
            next_cycle();
            wait_cnt++;
        end
        assert (!done) else
            stop_on_error($sformatf("done did not fall after load for packet %0d", pkt_idx));
        load = 1'b0;
        next_cycle();
    endtask

    // Budget scales with the stim file length
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_error($sformatf("Timeout: run did not end within %0d cycles", watchdog_cycles));
    end

    initial begin
        int               fd;
        int               n_fields;
        int               line_count;
        int               line_no;
        int               pkt_idx;
        int               idle_n;
        logic [8*256-1:0] line_buf;
        logic [7:0]       cmd;
        logic [15:0]      a;
        logic [15:0]      b;
        logic [15:0]      c;
        logic [15:0]      d;
        clk        = 1'b0;
        reset      = 1'b1;
        sck        = 1'b0;   // Mode 0 idles low
        sdi        = 1'b0;   // MOSI unused by the DUT
        load       = 1'b0;
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
        quat_w     = '0;
        quat_x     = '0;
        quat_y     = '0;
        quat_z     = '0;
        gyro_x     = '0;
        gyro_y     = '0;
        gyro_z     = '0;
        watchdog_cycles = 0;

        // First pass only counts lines for the watchdog
        fd = $fopen("bench/imu_spi_link_stim.txt", "r");
        assert (fd != 0) else stop_on_error("Cannot open bench/imu_spi_link_stim.txt");
        line_count = 0;
        while ($fgets(line_buf, fd) != 0) begin
            line_count++;
        end
        $fclose(fd);
        watchdog_cycles = line_count * CYCLES_PER_LINE;

        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;

        fd = $fopen("bench/imu_spi_link_stim.txt", "r");
        assert (fd != 0) else stop_on_error("Cannot reopen bench/imu_spi_link_stim.txt");
        line_no = 0;
        pkt_idx = 0;
        while ($fgets(line_buf, fd) != 0) begin
            line_no++;
            n_fields = $sscanf(line_buf, " %c", cmd);
            if (n_fields >= 1) begin             // Blank lines fall through
                case (cmd)
                    "Q": begin
                        n_fields = $sscanf(line_buf, " %c %h %h %h %h", cmd, a, b, c, d);
                        assert (n_fields == 5) else
                            stop_on_error($sformatf("Stim line %0d: Q needs 4 words", line_no));
                        send_quat(a, b, c, d);
                    end
                    "G": begin
                        n_fields = $sscanf(line_buf, " %c %h %h %h", cmd, a, b, c);
                        assert (n_fields == 4) else
                            stop_on_error($sformatf("Stim line %0d: G needs 3 words", line_no));
                        send_gyro(a, b, c);
                    end
                    "R": begin
                        n_fields = $sscanf(line_buf,
                            " %c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd,
                            exp_bytes[0], exp_bytes[1], exp_bytes[2], exp_bytes[3],
                            exp_bytes[4], exp_bytes[5], exp_bytes[6], exp_bytes[7],
                            exp_bytes[8], exp_bytes[9], exp_bytes[10], exp_bytes[11],
                            exp_bytes[12], exp_bytes[13], exp_bytes[14], exp_bytes[15]);
                        assert (n_fields == PACKET_BYTES + 1) else
                            stop_on_error($sformatf("Stim line %0d: R needs 16 bytes", line_no));
                        read_packet(pkt_idx);
                        pkt_idx++;
                    end
                    "N": begin
                        n_fields = $sscanf(line_buf, " %c %d", cmd, idle_n);
                        assert (n_fields == 2) else
                            stop_on_error($sformatf("Stim line %0d: N needs a count", line_no));
                        check_idle(idle_n);
                    end
                    "W": repeat (PAUSE_CYCLES) next_cycle();
                    "#": ;                          // Comment line
                    default: stop_on_error($sformatf("Stim line %0d: unknown command", line_no));
                endcase
            end
        end
        $fclose(fd);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== imu_link.f ====
hw/imu_link_pkg.sv
hw/imu_packet_if.sv
hw/imu_packet_framer.sv
hw/spi_packet_tx.sv
hw/imu_spi_link.sv
bench/imu_spi_link_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only -Wall --timing
TOP      = imu_spi_link_tb
RTL_TOP  = imu_spi_link
FILELIST = imu_link.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(SIM) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/imu_spi_link_stim.txt ====
# Q w x y z (hex) quat strobe | G x y z (hex) gyro strobe | R + 16 expected bytes (hex)
# N n (decimal) idle cycles with done low | W 20-cycle pause | lines with # are comments
# Quiet after reset
N 50
# Lone quaternion, gyro words still zero
Q 1234 5678 9abc def0
R AA 12 34 56 78 9A BC DE F0 00 00 00 00 00 00 01
N 40
# Quat and gyro queued behind an unread packet
Q 0001 fffe 7fff 8000
W
Q 0a0b 0c0d 0e0f 1011
G 0102 0304 0506
R AA 00 01 FF FE 7F FF 80 00 00 00 00 00 00 00 01
R AA 0A 0B 0C 0D 0E 0F 10 11 01 02 03 04 05 06 03
N 40
# Three quats behind an unread packet collapse to the last one
Q 1111 2222 3333 4444
W
Q 5555 6666 7777 8888
Q 0123 4567 89ab cdef
Q fedc ba98 7654 3210
R AA 11 11 22 22 33 33 44 44 01 02 03 04 05 06 01
R AA FE DC BA 98 76 54 32 10 01 02 03 04 05 06 01
N 40
# Lone gyro, then a gyro behind an unread quat packet
G a1a2 b1b2 c1c2
R AA FE DC BA 98 76 54 32 10 A1 A2 B1 B2 C1 C2 02
Q 7654 0000 ffff 0001
W
G 1357 2468 9bdf
R AA 76 54 00 00 FF FF 00 01 A1 A2 B1 B2 C1 C2 01
R AA 76 54 00 00 FF FF 00 01 13 57 24 68 9B DF 02
# Released with nothing new, no spurious packet
N 60
